/* Makefile */
VERILATOR ?= verilator
TOP       ?= acq_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TESTS FAILED
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/acq_pkg.sv */
package acq_pkg;

    // packet types on the link
    typedef enum logic [3:0] {
        BAG_INIT   = 4'd0,
        BAG_DIDX   = 4'd5,
        BAG_DPARAM = 4'd6,
        BAG_DDIDX  = 4'd7,
        BAG_DLINK  = 4'd8,
        BAG_DTYPE  = 4'd9,
        BAG_DTEMP  = 4'd10,
        BAG_DATA0  = 4'd13,
        BAG_DATA1  = 4'd14,
        BAG_ERROR  = 4'd15
    } btype_t;

    // command sequencer states
    typedef enum logic [2:0] {
        S_BOOT,
        S_LINK_INIT,
        S_LINK_WAIT,
        S_LINK_SEND,
        S_IDLE,
        S_ACK,
        S_WORK,
        S_SEND
    } seq_state_t;

    // operations broadcast to the converter channels
    typedef enum logic [1:0] {
        OP_INIT,
        OP_TYPE,
        OP_CONV
    } adc_op_t;

    localparam int NUM_CH           = 4;
    localparam int SAMPLE_W         = 16;
    localparam int CONV_CYCLES      = 4;
    localparam int LINK_WAIT_CYCLES = 12;
    localparam int NUM_SLOTS        = 6;

    // frame header addresses
    localparam logic [11:0] ADDR_DLINK = 12'hFCC;
    localparam logic [11:0] ADDR_DTYPE = 12'hFC0;
    localparam logic [11:0] ADDR_DTEMP = 12'hFC4;
    localparam logic [11:0] ADDR_DATA0 = 12'h000;
    localparam logic [11:0] ADDR_DATA1 = 12'h240;
    localparam logic [11:0] ADDR_DATA2 = 12'h480;
    localparam logic [11:0] ADDR_DATA3 = 12'h6C0;
    localparam logic [11:0] ADDR_DATA4 = 12'h900;
    localparam logic [11:0] ADDR_DATA5 = 12'hB40;

    localparam logic [7:0] FRAME_SYNC = 8'hA5;

endpackage

/* source/acq_top.sv */
`timescale 1ns/1ns

module acq_top (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        cmd_valid,
    input  logic [7:0]                                  cmd_byte,
    input  logic [acq_pkg::NUM_CH*acq_pkg::SAMPLE_W-1:0] adc_sample,
    output logic [7:0]                                  tx_data,
    output logic                                        tx_valid,
    input  logic                                        tx_ready,
    input  logic                                        tx_abort,
    output logic                                        frame_done
);
    import acq_pkg::*;

    logic                       cmd_pending;
    logic                       cmd_ack;
    btype_t                     cmd_type;
    logic                       adc_start;
    adc_op_t                    adc_op;
    logic                       adc_done;
    logic                       ch_start;
    adc_op_t                    ch_op;
    logic [NUM_CH-1:0]          ch_done;
    logic [NUM_CH*SAMPLE_W-1:0] ch_sample;
    logic                       frame_start;
    btype_t                     frame_btype;
    logic [11:0]                frame_addr;
    logic [11:0]                frame_dlen;

    cmd_rx u_cmd_rx (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_byte    (cmd_byte),
        .cmd_ack     (cmd_ack),
        .cmd_pending (cmd_pending),
        .cmd_type    (cmd_type)
    );

    console u_console (
        .clk         (clk),
        .rst         (rst),
        .cmd_pending (cmd_pending),
        .cmd_type    (cmd_type),
        .cmd_ack     (cmd_ack),
        .adc_start   (adc_start),
        .adc_op      (adc_op),
        .adc_done    (adc_done),
        .frame_start (frame_start),
        .frame_btype (frame_btype),
        .frame_addr  (frame_addr),
        .frame_dlen  (frame_dlen),
        .frame_done  (frame_done),
        .tx_abort    (tx_abort)
    );

    adc_ctrl u_adc_ctrl (
        .clk       (clk),
        .rst       (rst),
        .adc_start (adc_start),
        .adc_op    (adc_op),
        .adc_done  (adc_done),
        .ch_start  (ch_start),
        .ch_op     (ch_op),
        .ch_done   (ch_done)
    );

    // one converter per sample lane
    for (genvar i = 0; i < NUM_CH; i++) begin : gen_ch
        adc_channel u_ch (
            .clk       (clk),
            .rst       (rst),
            .ch_start  (ch_start),
            .ch_op     (ch_op),
            .sample_in (adc_sample[i*SAMPLE_W +: SAMPLE_W]),
            .ch_done   (ch_done[i]),
            .ch_sample (ch_sample[i*SAMPLE_W +: SAMPLE_W])
        );
    end

    frame_tx u_frame_tx (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .frame_btype (frame_btype),
        .frame_addr  (frame_addr),
        .frame_dlen  (frame_dlen),
        .ch_sample   (ch_sample),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_abort    (tx_abort),
        .frame_done  (frame_done)
    );

endmodule

/* source/adc_channel.sv */
`timescale 1ns/1ns

module adc_channel (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ch_start,
    input  acq_pkg::adc_op_t             ch_op,
    input  logic [acq_pkg::SAMPLE_W-1:0] sample_in,
    output logic                         ch_done,
    output logic [acq_pkg::SAMPLE_W-1:0] ch_sample
);
    import acq_pkg::*;

    // zero means no conversion running
    logic [$clog2(CONV_CYCLES):0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            ch_done <= 1'b0;
        end else begin
            ch_done <= 1'b0;
            if (ch_start) begin
                if (ch_op == OP_CONV)
                    cnt <= $bits(cnt)'(CONV_CYCLES - 1);
                else
                    ch_done <= 1'b1;
            end else if (cnt == 1) begin
                cnt     <= '0;
                ch_done <= 1'b1;
            end else if (cnt != 0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // sample register that loads together with ch_done
    always_ff @(posedge clk) begin
        if (ch_start && ch_op == OP_INIT)
            ch_sample <= '0;
        else if (!ch_start && cnt == 1)
            ch_sample <= sample_in;
    end

endmodule

/* source/adc_ctrl.sv */
`timescale 1ns/1ns

module adc_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       adc_start,
    input  acq_pkg::adc_op_t           adc_op,
    output logic                       adc_done,
    output logic                       ch_start,
    output acq_pkg::adc_op_t           ch_op,
    input  logic [acq_pkg::NUM_CH-1:0] ch_done
);
    import acq_pkg::*;

    logic              busy;
    logic [NUM_CH-1:0] seen;
    logic              all_done;

    // channels may finish on different clocks
    assign all_done = &(seen | ch_done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ch_start <= 1'b0;
            ch_op    <= OP_INIT;
            adc_done <= 1'b0;
            busy     <= 1'b0;
            seen     <= '0;
        end else begin
            ch_start <= adc_start;
            adc_done <= 1'b0;
            if (adc_start) begin
                ch_op <= adc_op;
                busy  <= 1'b1;
            end
            if (busy) begin
                if (all_done) begin
                    adc_done <= 1'b1;
                    busy     <= 1'b0;
                    seen     <= '0;
                end else begin
                    seen <= seen | ch_done;
                end
            end
        end
    end

    a_one_op: assert property (@(posedge clk) disable iff (rst)
        adc_start |-> !busy);

endmodule

/* source/cmd_rx.sv */
`timescale 1ns/1ns

module cmd_rx (
    input  logic            clk,
    input  logic            rst,
    input  logic            cmd_valid,
    input  logic [7:0]      cmd_byte,
    input  logic            cmd_ack,
    output logic            cmd_pending,
    output acq_pkg::btype_t cmd_type
);
    import acq_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cmd_pending <= 1'b0;
        else if (cmd_ack)
            cmd_pending <= 1'b0;
        else if (cmd_valid)
            cmd_pending <= 1'b1;
    end

    // holding register that ignores new bytes while one is pending
    always_ff @(posedge clk) begin
        if (cmd_valid && !cmd_pending)
            cmd_type <= btype_t'(cmd_byte[3:0]);
    end

    a_ack_pending: assert property (@(posedge clk) disable iff (rst)
        cmd_ack |-> cmd_pending);

endmodule

/* source/console.sv */
`timescale 1ns/1ns

module console (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_pending,
    input  acq_pkg::btype_t  cmd_type,
    output logic             cmd_ack,
    output logic             adc_start,
    output acq_pkg::adc_op_t adc_op,
    input  logic             adc_done,
    output logic             frame_start,
    output acq_pkg::btype_t  frame_btype,
    output logic [11:0]      frame_addr,
    output logic [11:0]      frame_dlen,
    input  logic             frame_done,
    input  logic             tx_abort
);
    import acq_pkg::*;

    seq_state_t                          state;
    logic [$clog2(LINK_WAIT_CYCLES)-1:0] wait_cnt;
    logic [$clog2(NUM_SLOTS)-1:0]        slot;
    logic [11:0]                         slot_addr;
    logic                                frame_open;
    logic                                link_abort;

    // frame_tx only drops the link frame, and only once it is on the wire
    assign link_abort = tx_abort && frame_open && (frame_btype == BAG_DLINK);

    always_comb begin
        case (slot)
            3'd1:    slot_addr = ADDR_DATA1;
            3'd2:    slot_addr = ADDR_DATA2;
            3'd3:    slot_addr = ADDR_DATA3;
            3'd4:    slot_addr = ADDR_DATA4;
            3'd5:    slot_addr = ADDR_DATA5;
            default: slot_addr = ADDR_DATA0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= S_BOOT;
            cmd_ack     <= 1'b0;
            adc_start   <= 1'b0;
            adc_op      <= OP_INIT;
            frame_start <= 1'b0;
            frame_btype <= BAG_INIT;
            frame_addr  <= '0;
            frame_dlen  <= '0;
            wait_cnt    <= '0;
            slot        <= '0;
        end else begin
            cmd_ack     <= 1'b0;
            adc_start   <= 1'b0;
            frame_start <= 1'b0;
            case (state)
                S_BOOT: begin
                    adc_start <= 1'b1;
                    adc_op    <= OP_INIT;
                    state     <= S_LINK_INIT;
                end
                S_LINK_INIT: begin
                    if (adc_done) begin
                        wait_cnt <= '0;
                        state    <= S_LINK_WAIT;
                    end
                end
                S_LINK_WAIT: begin
                    if (wait_cnt == $bits(wait_cnt)'(LINK_WAIT_CYCLES - 1)) begin
                        frame_start <= 1'b1;
                        frame_btype <= BAG_DLINK;
                        frame_addr  <= ADDR_DLINK;
                        frame_dlen  <= 12'd2;
                        state       <= S_LINK_SEND;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                S_LINK_SEND: begin
                    if (frame_done) begin
                        state <= S_IDLE;
                    end else if (link_abort) begin
                        // line error restarts the settle time before the resend
                        wait_cnt <= '0;
                        state    <= S_LINK_WAIT;
                    end
                end
                S_IDLE: begin
                    if (cmd_pending) begin
                        cmd_ack <= 1'b1;
                        state   <= S_ACK;
                    end
                end
                // cmd_ack is high here and cmd_type is still valid
                S_ACK: begin
                    case (cmd_type)
                        BAG_DIDX: begin
                            adc_start   <= 1'b1;
                            adc_op      <= OP_TYPE;
                            frame_btype <= BAG_DTYPE;
                            frame_addr  <= ADDR_DTYPE;
                            frame_dlen  <= 12'd2;
                            state       <= S_WORK;
                        end
                        BAG_DPARAM: begin
                            adc_start   <= 1'b1;
                            adc_op      <= OP_CONV;
                            frame_btype <= BAG_DTEMP;
                            frame_addr  <= ADDR_DTEMP;
                            frame_dlen  <= 12'd2;
                            state       <= S_WORK;
                        end
                        BAG_DDIDX: begin
                            adc_start   <= 1'b1;
                            adc_op      <= OP_CONV;
                            frame_btype <= slot[0] ? BAG_DATA1 : BAG_DATA0;
                            frame_addr  <= slot_addr;
                            frame_dlen  <= 12'(2 * NUM_CH);
                            slot        <= (slot == $bits(slot)'(NUM_SLOTS - 1)) ?
                                           '0 : slot + 1'b1;
                            state       <= S_WORK;
                        end
                        // error reports and unknown commands get no reply
                        default: state <= S_IDLE;
                    endcase
                end
                S_WORK: begin
                    if (adc_done) begin
                        frame_start <= 1'b1;
                        state       <= S_SEND;
                    end
                end
                S_SEND: begin
                    if (frame_done)
                        state <= S_IDLE;
                end
                default: state <= S_BOOT;
            endcase
        end
    end

    // tracks the frame in frame_tx from start until done or dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            frame_open <= 1'b0;
        else if (frame_start)
            frame_open <= 1'b1;
        else if (frame_done || link_abort)
            frame_open <= 1'b0;
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        frame_start |-> !frame_open);

endmodule

/* source/frame_tx.sv */
`timescale 1ns/1ns

module frame_tx (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        frame_start,
    input  acq_pkg::btype_t                             frame_btype,
    input  logic [11:0]                                 frame_addr,
    input  logic [11:0]                                 frame_dlen,
    input  logic [acq_pkg::NUM_CH*acq_pkg::SAMPLE_W-1:0] ch_sample,
    output logic [7:0]                                  tx_data,
    output logic                                        tx_valid,
    input  logic                                        tx_ready,
    input  logic                                        tx_abort,
    output logic                                        frame_done
);
    import acq_pkg::*;

    logic [12:0]               idx;
    logic [12:0]               pidx;
    logic [$clog2(NUM_CH)-1:0] wsel;
    logic [SAMPLE_W-1:0]       word;
    logic                      last;

    // four header bytes come before the payload
    assign pidx = idx - 13'd4;
    assign last = (idx == {1'b0, frame_dlen} + 13'd3);
    assign wsel = (frame_btype == BAG_DATA0 || frame_btype == BAG_DATA1) ?
                  pidx[$clog2(NUM_CH):1] : '0;

    always_comb begin
        if (frame_btype == BAG_DLINK || frame_btype == BAG_DTYPE)
            word = SAMPLE_W'(NUM_CH);
        else
            word = ch_sample[wsel*SAMPLE_W +: SAMPLE_W];
    end

    always_comb begin
        case (idx)
            13'd0:   tx_data = FRAME_SYNC;
            13'd1:   tx_data = {4'h0, frame_btype};
            13'd2:   tx_data = {4'h0, frame_addr[11:8]};
            13'd3:   tx_data = frame_addr[7:0];
            // payload words go out high byte first
            default: tx_data = pidx[0] ? word[7:0] : word[SAMPLE_W-1 -: 8];
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_valid   <= 1'b0;
            frame_done <= 1'b0;
            idx        <= '0;
        end else begin
            frame_done <= 1'b0;
            if (!tx_valid) begin
                if (frame_start) begin
                    tx_valid <= 1'b1;
                    idx      <= '0;
                end
            end else if (tx_abort && frame_btype == BAG_DLINK) begin
                tx_valid <= 1'b0;
            end else if (tx_ready) begin
                if (last) begin
                    tx_valid   <= 1'b0;
                    frame_done <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> !tx_valid || $stable(tx_data));

endmodule

/* sources.f */
source/acq_pkg.sv
source/cmd_rx.sv
source/console.sv
source/adc_ctrl.sv
source/adc_channel.sv
source/frame_tx.sv
source/acq_top.sv
testbench/acq_tb.sv

/* testbench/acq_tb.sv */
`timescale 1ns/1ns

module acq_tb;
    import acq_pkg::*;

    localparam int TIMEOUT     = 2000;
    localparam int IDLE_CYCLES = 32;

    logic                       clk;
    logic                       rst;
    logic                       cmd_valid;
    logic [7:0]                 cmd_byte;
    logic [NUM_CH*SAMPLE_W-1:0] adc_sample;
    logic [7:0]                 tx_data;
    logic                       tx_valid;
    logic                       tx_ready;
    logic                       tx_abort;
    logic                       frame_done;

    logic [7:0]  rx_bytes[$];
    logic [7:0]  last_frame[$];
    logic [15:0] payload[$];
    int          frames_seen;
    int          frames_taken;
    int          aborts_seen;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          slot;

    acq_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // the sink takes about seven bytes in ten
    initial begin
        tx_ready = 1'b0;
        forever begin
            @(negedge clk);
            tx_ready = ($urandom % 10) < 7;
        end
    end

    // byte collector that drops a partial frame on a line error
    always @(posedge clk) begin
        if (rst) begin
            rx_bytes.delete();
        end else if (frame_done) begin
            last_frame = rx_bytes;
            rx_bytes.delete();
            frames_seen++;
        end else if (tx_valid && tx_abort) begin
            rx_bytes.delete();
            aborts_seen++;
        end else if (tx_valid && tx_ready) begin
            rx_bytes.push_back(tx_data);
        end
    end

    task automatic report_timeout(input string what);
        $display("ERROR: timeout at %0t while waiting for %s", $time, what);
        errors++;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_btype(input string name, input btype_t got, input btype_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %s (%0d) expected %s (%0d)",
                     $time, name, got.name(), got, exp.name(), exp);
            errors++;
        end
    endtask

    // expected frame is the header followed by the payload words high byte first
    task automatic receive_frame(input btype_t bt, input logic [11:0] addr);
        logic [7:0] exp[$];
        int         t;
        exp.push_back(FRAME_SYNC);
        exp.push_back({4'h0, bt});
        exp.push_back({4'h0, addr[11:8]});
        exp.push_back(addr[7:0]);
        foreach (payload[i]) begin
            exp.push_back(payload[i][15:8]);
            exp.push_back(payload[i][7:0]);
        end
        t = 0;
        while (frames_seen == frames_taken && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (frames_seen == frames_taken) begin
            report_timeout($sformatf("a %s frame", bt.name()));
        end else begin
            frames_taken++;
            if (frames_seen != frames_taken) begin
                $display("ERROR: an unexpected extra frame arrived before %0t", $time);
                errors++;
                frames_taken = frames_seen;
            end
            if (last_frame.size() != exp.size()) begin
                $display("ERROR: %s frame has %0d bytes instead of %0d",
                         bt.name(), last_frame.size(), exp.size());
                errors++;
            end else begin
                check_btype("frame btype", btype_t'(last_frame[1][3:0]), bt);
                foreach (exp[i])
                    check_byte($sformatf("tx_data byte %0d", i), last_frame[i], exp[i]);
            end
        end
    endtask

    // no frame may start while no reply is owed
    task automatic check_line_idle(input int cycles);
        int t;
        t = 0;
        while (!tx_valid && frames_seen == frames_taken && t < cycles) begin
            @(negedge clk);
            t++;
        end
        if (tx_valid || frames_seen != frames_taken) begin
            $display("ERROR: a frame was sent that no command asked for at %0t", $time);
            errors++;
        end
    endtask

    task automatic new_samples();
        for (int i = 0; i < NUM_CH; i++)
            adc_sample[i*SAMPLE_W +: SAMPLE_W] = 16'($urandom);
    endtask

    // strobe one command byte and wait until the sequencer has taken it
    task automatic send_cmd(input logic [3:0] kind);
        int t;
        t = 0;
        while (dut0.cmd_pending && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (dut0.cmd_pending)
            report_timeout("the command slot to free up");
        cmd_valid = 1'b1;
        cmd_byte  = {4'($urandom), kind};
        @(negedge clk);
        cmd_valid = 1'b0;
        check_bit("cmd_pending", dut0.cmd_pending, 1'b1);
        t = 0;
        while (dut0.cmd_pending && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (dut0.cmd_pending)
            report_timeout("the command to be acknowledged");
    endtask

    task automatic run_cmd(input logic [3:0] kind);
        new_samples();
        payload.delete();
        case (kind)
            BAG_DIDX: begin
                payload.push_back(16'(NUM_CH));
                send_cmd(kind);
                receive_frame(BAG_DTYPE, ADDR_DTYPE);
            end
            BAG_DPARAM: begin
                payload.push_back(adc_sample[SAMPLE_W-1:0]);
                send_cmd(kind);
                receive_frame(BAG_DTEMP, ADDR_DTEMP);
            end
            BAG_DDIDX: begin
                for (int i = 0; i < NUM_CH; i++)
                    payload.push_back(adc_sample[i*SAMPLE_W +: SAMPLE_W]);
                send_cmd(kind);
                // buffer slots sit 0x240 apart
                receive_frame((slot % 2) ? BAG_DATA1 : BAG_DATA0, 12'(slot * 'h240));
                slot = (slot + 1) % NUM_SLOTS;
            end
            // error and unknown commands get no reply
            default: begin
                send_cmd(kind);
                check_line_idle(IDLE_CYCLES);
            end
        endcase
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst          = 1'b0;
        slot         = 0;
        frames_taken = frames_seen;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        int t;
        int aborts;
        void'($urandom(61));
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_byte   = '0;
        adc_sample = '0;
        tx_abort   = 1'b0;

        apply_reset();
        check_bit("tx_valid", tx_valid, 1'b0);
        check_bit("frame_done", frame_done, 1'b0);
        payload.delete();
        payload.push_back(16'(NUM_CH));
        receive_frame(BAG_DLINK, ADDR_DLINK);
        end_test("link_after_reset");

        run_cmd(BAG_DIDX);
        end_test("type_query");

        run_cmd(BAG_DPARAM);
        end_test("param_request");

        repeat (8) run_cmd(BAG_DDIDX);
        end_test("data_slots");

        run_cmd(BAG_ERROR);
        run_cmd(4'h3);
        repeat (12) run_cmd(4'($urandom));
        run_cmd(BAG_DIDX);
        check_line_idle(IDLE_CYCLES);
        end_test("random_mix");

        apply_reset();
        aborts = aborts_seen;
        t = 0;
        while (rx_bytes.size() < 2 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (rx_bytes.size() < 2)
            report_timeout("the link frame to start");
        tx_abort = 1'b1;
        @(negedge clk);
        tx_abort = 1'b0;
        if (aborts_seen == aborts) begin
            $display("ERROR: the line error did not hit the link frame in flight");
            errors++;
        end
        payload.delete();
        payload.push_back(16'(NUM_CH));
        receive_frame(BAG_DLINK, ADDR_DLINK);
        end_test("link_abort");

        $display("tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
